//--- bench/tb_usb_ahb_slave.sv
`timescale 1ns/1ps

`include "usb_ahb_macros.svh"

module tb_usb_ahb_slave import usb_ahb_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int N_STATUS    = 40;
  localparam int N_DATA      = 40;
  localparam int N_PKT_PAIRS = 20;
  localparam int N_ILLEGAL   = 40;
  localparam int N_PIPE      = 80;
  localparam int N_XFERS     = N_STATUS + N_DATA + 2 * N_PKT_PAIRS + N_ILLEGAL + N_PIPE;
  // At most four cycles per transfer, margin for reset and drains
  localparam int WATCHDOG_NS = (N_XFERS * 4 + 100) * CLK_PERIOD;

  logic    tb_clk;
  logic    rst_n_i;
  logic    hsel_i;
  haddr_t  haddr_i;
  hsize_t  hsize_i;
  htrans_e htrans_i;
  logic    hwrite_i;
  word_t   hwdata_i;
  word_t   hrdata_o;
  logic    hresp_o, hready_o;
  logic    rx_data_ready_i, rx_transfer_active_i, rx_error_i;
  logic    tx_transfer_active_i, tx_error_i, buffer_reserved_i;
  occ_t    buffer_occupancy_i;
  word_t   rx_data_i;
  logic    get_rx_data_o, store_tx_data_o;
  word_t   tx_data_o;
  hsize_t  data_size_o;
  occ_t    tx_packet_data_size_o;

  logic [31:0] rng_state;
  // Write data owed to the transfer in its address phase
  word_t       pend_wdata;
  int          err_count;
  int          errs_before;
  int          tests_passed;
  int          tests_failed;

  usb_ahb_slave dut0 (.*);

  usb_ahb_checker chk0 (
    .*,
    .hrdata_i              (hrdata_o),
    .hready_i              (hready_o),
    .hresp_i               (hresp_o),
    .get_rx_data_i         (get_rx_data_o),
    .store_tx_data_i       (store_tx_data_o),
    .tx_data_i             (tx_data_o),
    .data_size_i           (data_size_o),
    .tx_packet_data_size_i (tx_packet_data_size_o),
    .err_count_o           (err_count)
  );

  always #(CLK_PERIOD / 2) tb_clk = ~tb_clk;

  // ******************************************************************
  // Stimulus helpers
  // ******************************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Indices 4 to 7 all map to the packet size register
  function automatic haddr_t reg_offset(input logic [2:0] idx);
    case (idx)
      3'd0:    return `USB_AHB_REG_DATA;
      3'd1:    return `USB_AHB_REG_STATUS;
      3'd2:    return `USB_AHB_REG_ERROR;
      3'd3:    return `USB_AHB_REG_OCC;
      default: return `USB_AHB_REG_PKTSIZE;
    endcase
  endfunction

  // Mostly a register, sometimes any address at all
  function automatic haddr_t pick_addr(input logic [31:0] r);
    if (r[3]) begin
      return haddr_t'(r[15:9]);
    end else begin
      return reg_offset(r[2:0]);
    end
  endfunction

  task automatic randomize_usb();
    logic [31:0] r;
    r = rand_word();
    rx_data_ready_i      = r[0];
    rx_transfer_active_i = r[1];
    rx_error_i           = r[2];
    tx_transfer_active_i = r[3];
    tx_error_i           = r[4];
    buffer_reserved_i    = r[5];
    buffer_occupancy_i   = r[14:8];
    rx_data_i            = rand_word();
  endtask

  // IDLE, BUSY or deselected, with junk address fields
  task automatic idle_bus();
    logic [31:0] r;
    r = rand_word();
    hsel_i   = r[0] && !r[2];
    htrans_i = r[2] ? NONSEQ : (r[1] ? BUSY : IDLE);
    haddr_i  = r[14:8];
    hsize_i  = r[17:16];
    hwrite_i = r[20];
  endtask

  // One bus cycle, entered 1 ns after a rising edge
  task automatic bus_slot(input logic go, input logic wr, input haddr_t a, input hsize_t sz);
    logic [31:0] r;
    hwdata_i   = pend_wdata;
    pend_wdata = rand_word();
    // Error response running, hold the address phase idle
    while (!hready_o) begin
      idle_bus();
      @(posedge tb_clk);
      #1;
    end
    if (go) begin
      r = rand_word();
      randomize_usb();
      hsel_i   = 1'b1;
      htrans_i = r[0] ? SEQ : NONSEQ;
      hwrite_i = wr;
      haddr_i  = a;
      hsize_i  = sz;
    end else begin
      idle_bus();
    end
    @(posedge tb_clk);
    #1;
  endtask

  task automatic one_transfer(input logic wr, input haddr_t a, input hsize_t sz, input int gaps);
    bus_slot(1'b1, wr, a, sz);
    repeat (gaps) bus_slot(1'b0, 1'b0, '0, '0);
  endtask

  task automatic finish_test(input string name);
    // Drain the last data phase and any error response
    repeat (3) bus_slot(1'b0, 1'b0, '0, '0);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d mismatches", name, err_count - errs_before);
    end
    errs_before = err_count;
  endtask

  // ******************************************************************
  // Test sequence
  // ******************************************************************

  initial begin
    logic [31:0] r;
    logic [1:0]  lo;
    logic        wr;
    hsize_t      sz;
    haddr_t      a;
    tb_clk = 1'b0;
    rst_n_i = 1'b0;
    rng_state = 32'h8843;
    pend_wdata = '0;
    errs_before = 0;
    tests_passed = 0;
    tests_failed = 0;
    hsel_i = 1'b0;
    haddr_i = '0;
    hsize_i = HSIZE_BYTE;
    htrans_i = IDLE;
    hwrite_i = 1'b0;
    hwdata_i = '0;
    rx_data_ready_i = 1'b0;
    rx_transfer_active_i = 1'b0;
    rx_error_i = 1'b0;
    tx_transfer_active_i = 1'b0;
    tx_error_i = 1'b0;
    buffer_reserved_i = 1'b0;
    buffer_occupancy_i = '0;
    rx_data_i = '0;
    repeat (4) @(posedge tb_clk);
    #1;
    rst_n_i = 1'b1;
    repeat (4) bus_slot(1'b0, 1'b0, '0, '0);
    finish_test("reset_state");
    // Status, error and occupancy reads
    repeat (N_STATUS) begin
      r = rand_word();
      a = reg_offset(3'd1 + 3'(r[9:8] % 2'd3));
      one_transfer(1'b0, a, hsize_t'(r[17:16] % 2'd3), 1);
    end
    finish_test("status_reads");
    repeat (N_DATA) begin
      r = rand_word();
      one_transfer(r[4], `USB_AHB_REG_DATA, hsize_t'(r[17:16] % 2'd3), 1);
    end
    finish_test("data_buffer");
    // Write, then read back the same register
    repeat (N_PKT_PAIRS) begin
      r = rand_word();
      sz = hsize_t'(r[17:16] % 2'd3);
      one_transfer(1'b1, `USB_AHB_REG_PKTSIZE, sz, 1);
      one_transfer(1'b0, `USB_AHB_REG_PKTSIZE, sz, 1);
    end
    finish_test("packet_size");
    repeat (N_ILLEGAL) begin
      r = rand_word();
      wr = r[4];
      sz = hsize_t'(r[17:16] % 2'd3);
      lo = (r[12:11] == 2'd0) ? 2'd1 : r[12:11];
      case (r[1:0])
        // Past the last register
        2'd0: a = haddr_t'(8'h14 + (r[15:8] % 8'd108));
        // Off a word boundary
        2'd1: a = reg_offset(r[10:8]) + haddr_t'(lo);
        2'd2: begin
          a = reg_offset(r[10:8]);
          sz = HSIZE_DOUBLE;
        end
        default: begin
          a = reg_offset(3'd1 + 3'(r[9:8] % 2'd3));
          wr = 1'b1;
        end
      endcase
      one_transfer(wr, a, sz, 1);
    end
    finish_test("illegal_access");
    // Mostly back to back, an idle gap now and then
    repeat (N_PIPE) begin
      r = rand_word();
      one_transfer(r[4], pick_addr(r), hsize_t'(r[17:16]), (r[21:20] == 2'd0) ? 1 : 0);
    end
    finish_test("pipelined");
    $display("tests passed %0d, tests failed %0d, mismatches %0d",
             tests_passed, tests_failed, err_count);
    if ((tests_failed == 0) && (err_count == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog for a hung bus
  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- bench/usb_ahb_checker.sv
`timescale 1ns/1ps

`include "usb_ahb_macros.svh"

module usb_ahb_checker import usb_ahb_pkg::*; (
  input  logic    tb_clk,
  input  logic    rst_n_i,
  // Bus inputs as driven into the DUT
  input  logic    hsel_i,
  input  haddr_t  haddr_i,
  input  hsize_t  hsize_i,
  input  htrans_e htrans_i,
  input  logic    hwrite_i,
  input  word_t   hwdata_i,
  // USB inputs as driven into the DUT
  input  logic    rx_data_ready_i, rx_transfer_active_i, rx_error_i,
  input  logic    tx_transfer_active_i, tx_error_i, buffer_reserved_i,
  input  occ_t    buffer_occupancy_i,
  input  word_t   rx_data_i,
  // DUT outputs under check
  input  word_t   hrdata_i,
  input  logic    hready_i, hresp_i, get_rx_data_i, store_tx_data_i,
  input  word_t   tx_data_i,
  input  hsize_t  data_size_i,
  input  occ_t    tx_packet_data_size_i,
  output int      err_count_o
);

  // Model of the transfer now in its data phase
  logic   m_init = 1'b0;
  logic   m_dphase;
  haddr_t m_addr;
  hsize_t m_size;
  logic   m_write;
  // Second cycle of an error response
  logic   m_err2;
  occ_t   m_pkt;
  int     errors = 0;
  logic   bad;
  logic   rd_ok;
  logic   exp_store;

  assign err_count_o = errors;

  // Register map rules, exact offsets only
  function automatic logic illegal_access(input haddr_t a, input hsize_t s, input logic wr);
    logic mapped;
    logic ro;
    ro = (a == `USB_AHB_REG_STATUS) || (a == `USB_AHB_REG_ERROR) || (a == `USB_AHB_REG_OCC);
    mapped = ro || (a == `USB_AHB_REG_DATA) || (a == `USB_AHB_REG_PKTSIZE);
    return !mapped || (s == HSIZE_DOUBLE) || (wr && ro);
  endfunction

  // Expected read data, unused bits zero
  function automatic word_t read_value(input haddr_t a);
    word_t v;
    v = '0;
    case (a)
      `USB_AHB_REG_DATA:    v = rx_data_i;
      `USB_AHB_REG_STATUS:  v[3:0] = {buffer_reserved_i, tx_transfer_active_i,
                                      rx_transfer_active_i, rx_data_ready_i};
      `USB_AHB_REG_ERROR:   v[1:0] = {tx_error_i, rx_error_i};
      `USB_AHB_REG_OCC:     v[`USB_AHB_OCC_W-1:0] = buffer_occupancy_i;
      `USB_AHB_REG_PKTSIZE: v[`USB_AHB_OCC_W-1:0] = m_pkt;
      default:              v = '0;
    endcase
    return v;
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s expected %h actual %h at %0t ns", name, exp, act, $time);
    end
  endtask

  // ******************************************************************
  // Compare mid cycle, then step the model to the next edge
  // ******************************************************************

  always @(negedge tb_clk) begin
    if (m_init) begin
      bad = m_dphase && illegal_access(m_addr, m_size, m_write);
      rd_ok = m_dphase && !bad && !m_write;
      exp_store = m_dphase && !bad && m_write && (m_addr == `USB_AHB_REG_DATA);
      check_value("hready_o", word_t'(!bad), word_t'(hready_i));
      check_value("hresp_o", word_t'(bad || m_err2), word_t'(hresp_i));
      check_value("get_rx_data_o", word_t'(rd_ok && (m_addr == `USB_AHB_REG_DATA)),
                  word_t'(get_rx_data_i));
      check_value("store_tx_data_o", word_t'(exp_store), word_t'(store_tx_data_i));
      check_value("tx_packet_data_size_o", word_t'(m_pkt), word_t'(tx_packet_data_size_i));
      if (rd_ok) begin
        check_value("hrdata_o", read_value(m_addr), hrdata_i);
      end
      // Pushed word and its size only matter with the store pulse
      if (exp_store) begin
        check_value("tx_data_o", hwdata_i, tx_data_i);
        check_value("data_size_o", word_t'(m_size), word_t'(data_size_i));
      end
      if (m_dphase && !bad && m_write && (m_addr == `USB_AHB_REG_PKTSIZE)) begin
        m_pkt = hwdata_i[`USB_AHB_OCC_W-1:0];
      end
      m_err2 = bad;
      // Accepted only while hready is high
      m_dphase = hsel_i && !bad && ((htrans_i == NONSEQ) || (htrans_i == SEQ));
      if (m_dphase) begin
        m_addr  = haddr_i;
        m_size  = hsize_i;
        m_write = hwrite_i;
      end
    end
    if (!rst_n_i) begin
      m_init   = 1'b1;
      m_dphase = 1'b0;
      m_err2   = 1'b0;
      m_pkt    = '0;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_usb_ahb_slave -f verilog.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verilog.f
+incdir+verilog
verilog/usb_ahb_pkg.sv
verilog/usb_reg_req_if.sv
verilog/ahb_slave_front.sv
verilog/usb_endpoint_regs.sv
verilog/usb_ahb_slave.sv
bench/usb_ahb_checker.sv
bench/tb_usb_ahb_slave.sv

//--- verilog/ahb_slave_front.sv
`timescale 1ns/1ps

module ahb_slave_front import usb_ahb_pkg::*; (
  input  logic         tb_clk,
  input  logic         rst_n_i,
  // AHB-Lite slave side
  input  logic         hsel_i,
  input  haddr_t       haddr_i,
  input  hsize_t       hsize_i,
  input  htrans_e      htrans_i,
  input  logic         hwrite_i,
  input  word_t        hwdata_i,
  output word_t        hrdata_o,
  output logic         hready_o,
  output logic         hresp_o,
  // Register request
  usb_reg_req_if.front req
);

  logic        accept;
  logic        dphase_q;
  haddr_t      addr_q;
  hsize_t      size_q;
  logic        write_q;
  resp_state_e resp_q;
  resp_state_e resp_cur;
  resp_state_e resp_d;

  // ******************************************************************
  // Address phase
  // ******************************************************************

  // Only NONSEQ and SEQ count, BUSY and IDLE are ignored
  // No capture while hready_o is low
  assign accept = hsel_i && hready_o &&
                  ((htrans_i == NONSEQ) || (htrans_i == SEQ));

  // Marks the first data phase cycle
  always_ff @(posedge tb_clk) begin
    if (!rst_n_i) begin
      dphase_q <= 1'b0;
    end else begin
      dphase_q <= accept;
    end
  end

  // Address phase controls held for the data phase
  always_ff @(posedge tb_clk) begin
    if (accept) begin
      addr_q  <= haddr_i;
      size_q  <= hsize_i;
      write_q <= hwrite_i;
    end
  end

  // ******************************************************************
  // Data phase request
  // ******************************************************************

  assign req.req_valid = dphase_q;
  assign req.req_write = write_q;
  assign req.req_addr  = addr_q;
  assign req.req_size  = size_q;

  // Write data arrives in the data phase itself
  assign req.req_wdata = hwdata_i;

  // Read data straight from the register mux
  assign hrdata_o = req.req_rdata;

  // ******************************************************************
  // Error response FSM
  // ******************************************************************

  // Illegal request enters ERR_FIRST in its own data phase cycle
  always_comb begin
    resp_cur = resp_q;
    if ((resp_q == OKAY) && req.req_valid && req.req_err) begin
      resp_cur = ERR_FIRST;
    end
  end

  // ERR_FIRST then ERR_SECOND then back to OKAY
  always_comb begin
    case (resp_cur)
      ERR_FIRST:  resp_d = ERR_SECOND;
      ERR_SECOND: resp_d = OKAY;
      default:    resp_d = OKAY;
    endcase
  end

  always_ff @(posedge tb_clk) begin
    if (!rst_n_i) begin
      resp_q <= OKAY;
    end else begin
      resp_q <= resp_d;
    end
  end

  // Low hready only in the first error cycle
  assign hready_o = (resp_cur != ERR_FIRST);
  // hresp high through both error cycles
  assign hresp_o  = (resp_cur != OKAY);

endmodule

//--- verilog/usb_ahb_macros.svh
`ifndef USB_AHB_MACROS_SVH
`define USB_AHB_MACROS_SVH

// ********************************************************************
// Bus and buffer widths
// ********************************************************************

// Address bits seen by the slave, 128 byte window
`define USB_AHB_ADDR_W 7

// One AHB word
`define USB_AHB_DATA_W 32

// Buffer occupancy and packet length in bytes
`define USB_AHB_OCC_W 7

// ********************************************************************
// Register window offsets
// ********************************************************************

// Pops receive words on read, pushes transmit words on write
`define USB_AHB_REG_DATA 7'h00

// Read only endpoint flags
`define USB_AHB_REG_STATUS 7'h04
`define USB_AHB_REG_ERROR 7'h08
`define USB_AHB_REG_OCC 7'h0C

// Read/write transmit packet length
`define USB_AHB_REG_PKTSIZE 7'h10

`endif

//--- verilog/usb_ahb_pkg.sv
`include "usb_ahb_macros.svh"

package usb_ahb_pkg;

  // ******************************************************************
  // Vector types
  // ******************************************************************

  // Byte address inside the register window
  typedef logic [`USB_AHB_ADDR_W-1:0] haddr_t;

  // Read and write data word
  typedef logic [`USB_AHB_DATA_W-1:0] word_t;

  // HSIZE with the upper bit dropped
  typedef logic [1:0] hsize_t;

  // Byte count for occupancy and packet size
  typedef logic [`USB_AHB_OCC_W-1:0] occ_t;

  // Size codes
  localparam hsize_t HSIZE_BYTE   = 2'd0;
  localparam hsize_t HSIZE_HALF   = 2'd1;
  localparam hsize_t HSIZE_WORD   = 2'd2;
  localparam hsize_t HSIZE_DOUBLE = 2'd3;

  // ******************************************************************
  // Enumerations
  // ******************************************************************

  // HTRANS encoding, BUSY handled like IDLE
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Two cycle AHB error response
  typedef enum logic [1:0] {
    OKAY       = 2'b00,
    ERR_FIRST  = 2'b01,
    ERR_SECOND = 2'b10
  } resp_state_e;

endpackage

//--- verilog/usb_ahb_slave.sv
`timescale 1ns/1ps

module usb_ahb_slave import usb_ahb_pkg::*; (
  input  logic    tb_clk,
  input  logic    rst_n_i,
  // AHB-Lite slave side
  input  logic    hsel_i,
  input  haddr_t  haddr_i,
  input  hsize_t  hsize_i,
  input  htrans_e htrans_i,
  input  logic    hwrite_i,
  input  word_t   hwdata_i,
  output word_t   hrdata_o,
  output logic    hresp_o,
  output logic    hready_o,
  // USB endpoint inputs
  input  logic    rx_data_ready_i,
  input  logic    rx_transfer_active_i,
  input  logic    rx_error_i,
  input  logic    tx_transfer_active_i,
  input  logic    tx_error_i,
  input  logic    buffer_reserved_i,
  input  occ_t    buffer_occupancy_i,
  input  word_t   rx_data_i,
  // USB endpoint outputs
  output logic    get_rx_data_o,
  output logic    store_tx_data_o,
  output word_t   tx_data_o,
  output hsize_t  data_size_o,
  output occ_t    tx_packet_data_size_o
);

  // Data phase request between bus front and registers
  usb_reg_req_if reg_req ();

  // ******************************************************************
  // AHB-Lite bus front
  // ******************************************************************

  ahb_slave_front u_front (
    .tb_clk   (tb_clk),
    .rst_n_i  (rst_n_i),
    .hsel_i   (hsel_i),
    .haddr_i  (haddr_i),
    .hsize_i  (hsize_i),
    .htrans_i (htrans_i),
    .hwrite_i (hwrite_i),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o),
    .req      (reg_req)
  );

  // ******************************************************************
  // Endpoint register block
  // ******************************************************************

  usb_endpoint_regs u_regs (
    .tb_clk                (tb_clk),
    .rst_n_i               (rst_n_i),
    .req                   (reg_req),
    .rx_data_ready_i       (rx_data_ready_i),
    .rx_transfer_active_i  (rx_transfer_active_i),
    .rx_error_i            (rx_error_i),
    .tx_transfer_active_i  (tx_transfer_active_i),
    .tx_error_i            (tx_error_i),
    .buffer_reserved_i     (buffer_reserved_i),
    .buffer_occupancy_i    (buffer_occupancy_i),
    .rx_data_i             (rx_data_i),
    .get_rx_data_o         (get_rx_data_o),
    .store_tx_data_o       (store_tx_data_o),
    .tx_data_o             (tx_data_o),
    .data_size_o           (data_size_o),
    .tx_packet_data_size_o (tx_packet_data_size_o)
  );

endmodule

//--- verilog/usb_endpoint_regs.sv
`timescale 1ns/1ps

`include "usb_ahb_macros.svh"

module usb_endpoint_regs import usb_ahb_pkg::*; (
  input  logic        tb_clk,
  input  logic        rst_n_i,
  // Register request from the bus front
  usb_reg_req_if.regs req,
  // USB endpoint inputs
  input  logic        rx_data_ready_i,
  input  logic        rx_transfer_active_i,
  input  logic        rx_error_i,
  input  logic        tx_transfer_active_i,
  input  logic        tx_error_i,
  input  logic        buffer_reserved_i,
  input  occ_t        buffer_occupancy_i,
  input  word_t       rx_data_i,
  // USB endpoint outputs
  output logic        get_rx_data_o,
  output logic        store_tx_data_o,
  output word_t       tx_data_o,
  output hsize_t      data_size_o,
  output occ_t        tx_packet_data_size_o
);

  haddr_t word_addr;
  logic   sel_data;
  logic   sel_status;
  logic   sel_error;
  logic   sel_occ;
  logic   sel_pkt;
  logic   mapped;
  logic   aligned;
  logic   size_ok;
  logic   ro_write;
  logic   legal;
  logic   rd_ok;
  logic   pkt_wr;
  word_t  rd_mux;
  occ_t   pkt_size_q;

  // ******************************************************************
  // Address decode
  // ******************************************************************

  // Word granular decode, low bits checked apart
  assign word_addr = {req.req_addr[`USB_AHB_ADDR_W-1:2], 2'b00};

  assign sel_data   = (word_addr == `USB_AHB_REG_DATA);
  assign sel_status = (word_addr == `USB_AHB_REG_STATUS);
  assign sel_error  = (word_addr == `USB_AHB_REG_ERROR);
  assign sel_occ    = (word_addr == `USB_AHB_REG_OCC);
  assign sel_pkt    = (word_addr == `USB_AHB_REG_PKTSIZE);

  assign mapped = sel_data || sel_status || sel_error || sel_occ || sel_pkt;

  // No lane steering, every access sits on a word boundary
  assign aligned = (req.req_addr[1:0] == 2'b00);

  // Anything above one word is refused
  always_comb begin
    case (req.req_size)
      HSIZE_BYTE, HSIZE_HALF, HSIZE_WORD: size_ok = 1'b1;
      HSIZE_DOUBLE:                        size_ok = 1'b0;
      default:                             size_ok = 1'b0;
    endcase
  end

  // Status, error and occupancy are read only
  assign ro_write = req.req_write && (sel_status || sel_error || sel_occ);

  // ******************************************************************
  // Legality check
  // ******************************************************************

  assign req.req_err = !mapped || !aligned || !size_ok || ro_write;

  // Only this qualifies strobes and register updates
  assign legal = req.req_valid && !req.req_err;
  assign rd_ok = legal && !req.req_write;

  // ******************************************************************
  // Read mux
  // ******************************************************************

  always_comb begin
    rd_mux = '0;
    if (sel_data) begin
      // Receive word from the endpoint buffer
      rd_mux = rx_data_i;
    end else if (sel_status) begin
      rd_mux[0] = rx_data_ready_i;
      rd_mux[1] = rx_transfer_active_i;
      rd_mux[2] = tx_transfer_active_i;
      rd_mux[3] = buffer_reserved_i;
    end else if (sel_error) begin
      rd_mux[0] = rx_error_i;
      rd_mux[1] = tx_error_i;
    end else if (sel_occ) begin
      rd_mux[`USB_AHB_OCC_W-1:0] = buffer_occupancy_i;
    end else if (sel_pkt) begin
      rd_mux[`USB_AHB_OCC_W-1:0] = pkt_size_q;
    end
  end

  // Zero outside legal read data phases
  assign req.req_rdata = rd_ok ? rd_mux : '0;

  // ******************************************************************
  // Packet size register
  // ******************************************************************

  // Low 7 bits of the written word, whatever the size
  assign pkt_wr = legal && req.req_write && sel_pkt;

  always_ff @(posedge tb_clk) begin
    if (!rst_n_i) begin
      pkt_size_q <= '0;
    end else if (pkt_wr) begin
      pkt_size_q <= req.req_wdata[`USB_AHB_OCC_W-1:0];
    end
  end

  assign tx_packet_data_size_o = pkt_size_q;

  // ******************************************************************
  // Buffer strobes
  // ******************************************************************

  // One pulse per legal data phase, no occupancy check
  assign get_rx_data_o   = rd_ok && sel_data;
  assign store_tx_data_o = legal && req.req_write && sel_data;

  // Word and size valid with the store pulse
  assign tx_data_o   = store_tx_data_o ? req.req_wdata : '0;
  assign data_size_o = store_tx_data_o ? req.req_size : HSIZE_BYTE;

endmodule

//--- verilog/usb_reg_req_if.sv
`timescale 1ns/1ps

interface usb_reg_req_if import usb_ahb_pkg::*; ();

  // Request, valid only in the first data phase cycle
  logic   req_valid;
  logic   req_write;
  haddr_t req_addr;
  hsize_t req_size;
  word_t  req_wdata;

  // Answer, combinational in the same cycle
  word_t  req_rdata;
  logic   req_err;

  // Bus side issues the request
  modport front (
    output req_valid,
    output req_write,
    output req_addr,
    output req_size,
    output req_wdata,
    input  req_rdata,
    input  req_err
  );

  // Register block decodes and answers
  modport regs (
    input  req_valid,
    input  req_write,
    input  req_addr,
    input  req_size,
    input  req_wdata,
    output req_rdata,
    output req_err
  );

endinterface
